// ==== game_defines.svh ====
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// screen geometry in pixels
`define SCREEN_W 160
`define SCREEN_H 120

// every sprite is a square block
`define SPRITE_W 40
`define SPRITE_H 40

// enemy row and its three columns
`define ENEMY_Y     6
`define COL_LEFT_X  20
`define COL_MID_X   60
`define COL_RIGHT_X 100

// bottom row, hands either side of the player
`define HAND_Y       70
`define LEFT_HAND_X  0
`define PLAYER_X     40
`define RIGHT_HAND_X 80

// rgb, one bit per channel
`define ENEMY_COLOUR  3'b100
`define HAND_COLOUR   3'b111
`define PLAYER_COLOUR 3'b010
`define ERASE_COLOUR  3'b000

// move pacing in clock cycles
`define CALM_PERIOD       500
`define AGGRESSIVE_PERIOD 250
`define AGGRESSIVE_HEALTH 6

`endif

// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;
	typedef logic [2:0] colour_t;
	typedef logic [3:0] health_t;

	// one frame buffer write
	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		colour_t  colour;
	} pixel_t;

	// one flat rectangle to draw
	typedef struct packed {
		coord_x_t base_x;
		coord_y_t base_y;
		colour_t  colour;
	} sprite_t;

	// aggressive twin sits three codes above its calm state
	typedef enum logic [2:0] {
		LEFT_CALM         = 3'd0,
		MIDDLE_CALM       = 3'd1,
		RIGHT_CALM        = 3'd2,
		LEFT_AGGRESSIVE   = 3'd3,
		MIDDLE_AGGRESSIVE = 3'd4,
		RIGHT_AGGRESSIVE  = 3'd5,
		DEAD              = 3'd6
	} enemy_state_t;

	typedef enum logic [2:0] {
		DRAW_ENEMY,
		DRAW_LEFT,
		DRAW_PLAYER,
		DRAW_RIGHT,
		WAIT_MOVE,
		STEP,
		REDRAW,
		HALT
	} seq_state_t;

endpackage

`default_nettype wire

// ==== sprite_blitter.sv ====
`default_nettype none
`include "game_defines.svh"

module sprite_blitter (
	input  wire                     clock,
	input  wire                     reset_n,
	input  wire                     start,
	input  wire game_pkg::sprite_t  sprite,
	output logic                    done,
	output game_pkg::pixel_t        pixel,
	output logic                    pixel_req,
	input  wire                     pixel_ack
);
	import game_pkg::*;

	sprite_t    block;
	logic       busy;
	logic [5:0] col;
	logic [5:0] row;
	logic       last_col;
	logic       last_row;

	assign last_col = (col == 6'(`SPRITE_W - 1));
	assign last_row = (row == 6'(`SPRITE_H - 1));

	// current pixel, only moves while req is low
	assign pixel.x      = block.base_x + coord_x_t'(col);
	assign pixel.y      = block.base_y + coord_y_t'(row);
	assign pixel.colour = block.colour;

	always_ff @(posedge clock)
	begin
		if (start)
			block <= sprite;
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			busy      <= 1'b0;
			pixel_req <= 1'b0;
			done      <= 1'b0;
			col       <= '0;
			row       <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				busy      <= 1'b1;
				pixel_req <= 1'b1;
				col       <= '0;
				row       <= '0;
			end
			else if (busy && pixel_req)
			begin
				// frame buffer has taken the pixel
				if (pixel_ack)
					pixel_req <= 1'b0;
			end
			else if (busy && !pixel_ack)
			begin
				// ack is back low, next pixel or finish
				if (last_col && last_row)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				else
				begin
					pixel_req <= 1'b1;
					if (last_col)
					begin
						col <= '0;
						row <= row + 6'd1;
					end
					else
						col <= col + 6'd1;
				end
			end
		end
	end

	// pixel held steady over a whole request
	assert property (@(posedge clock) disable iff (!reset_n)
		pixel_req && $past(pixel_req) |-> $stable(pixel));

	// sequencer waits for done before the next block
	assert property (@(posedge clock) disable iff (!reset_n)
		start |-> !busy);

endmodule

`default_nettype wire

// ==== move_timer.sv ====
`default_nettype none
`include "game_defines.svh"

module move_timer (
	input  wire  clock,
	input  wire  reset_n,
	input  wire  enable,
	input  wire  aggressive,
	output logic tick
);
	localparam int count_w = $clog2(`CALM_PERIOD);

	logic [count_w-1:0] count;
	logic [count_w-1:0] reload;

	// aggressive enemy moves twice as often
	assign reload = aggressive ? count_w'(`AGGRESSIVE_PERIOD - 1)
	                           : count_w'(`CALM_PERIOD - 1);

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			count <= count_w'(`CALM_PERIOD - 1);
			tick  <= 1'b0;
		end
		else
		begin
			tick <= 1'b0;
			if (!enable)
				count <= reload;
			else if (count == '0)
			begin
				tick  <= 1'b1;
				count <= reload;
			end
			else
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== enemy_behaviour.sv ====
`default_nettype none
`include "game_defines.svh"

module enemy_behaviour (
	input  wire                     clock,
	input  wire                     reset_n,
	input  wire                     step,
	input  wire game_pkg::health_t  health,
	input  wire                     dodge,
	output game_pkg::coord_x_t      enemy_x,
	output logic                    aggressive,
	output logic                    dead
);
	import game_pkg::*;

	enemy_state_t state;
	enemy_state_t moved;
	enemy_state_t next_state;
	coord_x_t     col_x;

	function automatic coord_x_t column_of(enemy_state_t s);
		case (s)
			MIDDLE_CALM, MIDDLE_AGGRESSIVE: return coord_x_t'(`COL_MID_X);
			RIGHT_CALM, RIGHT_AGGRESSIVE:   return coord_x_t'(`COL_RIGHT_X);
			default:                        return coord_x_t'(`COL_LEFT_X);
		endcase
	endfunction

	// column move, mood carried along
	always_comb
	begin
		case (state)
			LEFT_CALM:         moved = dodge ? RIGHT_CALM : MIDDLE_CALM;
			MIDDLE_CALM:       moved = dodge ? RIGHT_CALM : LEFT_CALM;
			RIGHT_CALM:        moved = dodge ? MIDDLE_CALM : LEFT_CALM;
			LEFT_AGGRESSIVE:   moved = dodge ? RIGHT_AGGRESSIVE : MIDDLE_AGGRESSIVE;
			MIDDLE_AGGRESSIVE: moved = dodge ? RIGHT_AGGRESSIVE : LEFT_AGGRESSIVE;
			RIGHT_AGGRESSIVE:  moved = dodge ? MIDDLE_AGGRESSIVE : LEFT_AGGRESSIVE;
			default:           moved = DEAD;
		endcase
	end

	// health 0 wins over the mood change
	always_comb
	begin
		if (health == '0)
			next_state = DEAD;
		else if (moved inside {LEFT_CALM, MIDDLE_CALM, RIGHT_CALM}
		         && health < health_t'(`AGGRESSIVE_HEALTH))
			next_state = enemy_state_t'(moved + 3'd3);
		else
			next_state = moved;
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= LEFT_CALM;
			col_x <= coord_x_t'(`COL_LEFT_X);
		end
		else if (step)
		begin
			state <= next_state;
			// a dead enemy stays where it fell
			if (next_state != DEAD)
				col_x <= column_of(next_state);
		end
	end

	assign enemy_x    = col_x;
	assign aggressive = state inside {LEFT_AGGRESSIVE, MIDDLE_AGGRESSIVE, RIGHT_AGGRESSIVE};
	assign dead       = (state == DEAD);

	// one move per timer tick
	assert property (@(posedge clock) disable iff (!reset_n)
		step |=> !step);

endmodule

`default_nettype wire

// ==== scene_sequencer.sv ====
`default_nettype none
`include "game_defines.svh"

module scene_sequencer (
	input  wire                      clock,
	input  wire                      reset_n,
	input  wire game_pkg::coord_x_t  enemy_x,
	input  wire                      dead,
	input  wire                      tick,
	input  wire                      blit_done,
	output logic                     timer_enable,
	output logic                     step,
	output logic                     blit_start,
	output game_pkg::sprite_t        sprite
);
	import game_pkg::*;

	seq_state_t state;
	logic       issued;
	logic       drawing;

	assign drawing      = state inside {DRAW_ENEMY, DRAW_LEFT, DRAW_PLAYER, DRAW_RIGHT, REDRAW};
	assign timer_enable = (state == WAIT_MOVE);
	assign step         = (state == STEP);

	// block for the current state, enemy unless a bottom row sprite
	always_comb
	begin
		sprite.base_x = enemy_x;
		sprite.base_y = coord_y_t'(`ENEMY_Y);
		sprite.colour = dead ? colour_t'(`ERASE_COLOUR) : colour_t'(`ENEMY_COLOUR);
		case (state)
			DRAW_LEFT:
			begin
				sprite.base_x = coord_x_t'(`LEFT_HAND_X);
				sprite.base_y = coord_y_t'(`HAND_Y);
				sprite.colour = colour_t'(`HAND_COLOUR);
			end
			DRAW_PLAYER:
			begin
				sprite.base_x = coord_x_t'(`PLAYER_X);
				sprite.base_y = coord_y_t'(`HAND_Y);
				sprite.colour = colour_t'(`PLAYER_COLOUR);
			end
			DRAW_RIGHT:
			begin
				sprite.base_x = coord_x_t'(`RIGHT_HAND_X);
				sprite.base_y = coord_y_t'(`HAND_Y);
				sprite.colour = colour_t'(`HAND_COLOUR);
			end
			// enemy block keeps the values above
			default:
				;
		endcase
	end

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state      <= DRAW_ENEMY;
			issued     <= 1'b0;
			blit_start <= 1'b0;
		end
		else
		begin
			blit_start <= 1'b0;
			// one start per draw state
			if (blit_done)
				issued <= 1'b0;
			else if (drawing && !issued)
			begin
				blit_start <= 1'b1;
				issued     <= 1'b1;
			end

			case (state)
				DRAW_ENEMY:
					if (blit_done)
						state <= DRAW_LEFT;
				DRAW_LEFT:
					if (blit_done)
						state <= DRAW_PLAYER;
				DRAW_PLAYER:
					if (blit_done)
						state <= DRAW_RIGHT;
				DRAW_RIGHT:
					if (blit_done)
						state <= WAIT_MOVE;
				WAIT_MOVE:
					if (tick)
						state <= STEP;
				STEP:
					state <= REDRAW;
				REDRAW:
					if (blit_done)
						state <= dead ? HALT : WAIT_MOVE;
				default:
					state <= HALT;
			endcase
		end
	end

	// timer only ticks out of the wait
	assert property (@(posedge clock) disable iff (!reset_n)
		tick |-> state == WAIT_MOVE);

endmodule

`default_nettype wire

// ==== game_top.sv ====
`default_nettype none

module game_top (
	input  wire                     clock,
	input  wire                     reset_n,
	input  wire game_pkg::health_t  health,
	input  wire                     dodge,
	output game_pkg::pixel_t        pixel,
	output logic                    pixel_req,
	input  wire                     pixel_ack
);
	import game_pkg::*;

	sprite_t  sprite;
	coord_x_t enemy_x;
	logic     blit_start;
	logic     blit_done;
	logic     timer_enable;
	logic     tick;
	logic     step;
	logic     aggressive;
	logic     dead;

	scene_sequencer u_scene_sequencer (
		.clock        (clock),
		.reset_n      (reset_n),
		.enemy_x      (enemy_x),
		.dead         (dead),
		.tick         (tick),
		.blit_done    (blit_done),
		.timer_enable (timer_enable),
		.step         (step),
		.blit_start   (blit_start),
		.sprite       (sprite)
	);

	sprite_blitter u_sprite_blitter (
		.clock     (clock),
		.reset_n   (reset_n),
		.start     (blit_start),
		.sprite    (sprite),
		.done      (blit_done),
		.pixel     (pixel),
		.pixel_req (pixel_req),
		.pixel_ack (pixel_ack)
	);

	move_timer u_move_timer (
		.clock      (clock),
		.reset_n    (reset_n),
		.enable     (timer_enable),
		.aggressive (aggressive),
		.tick       (tick)
	);

	enemy_behaviour u_enemy_behaviour (
		.clock      (clock),
		.reset_n    (reset_n),
		.step       (step),
		.health     (health),
		.dodge      (dodge),
		.enemy_x    (enemy_x),
		.aggressive (aggressive),
		.dead       (dead)
	);

endmodule

`default_nettype wire

// ==== tb_game_top.sv ====
`default_nettype none
`include "game_defines.svh"

module tb_game_top;
	timeunit 1ns;
	timeprecision 100ps;

	import game_pkg::*;

	// enemy as the testbench sees it between moves
	typedef struct packed {
		logic       gone;
		logic       angry;
		logic [1:0] col;
	} model_t;

	localparam int moves            = 8;
	localparam int total_blocks     = 4 + moves;
	localparam int pixels_per_block = `SPRITE_W * `SPRITE_H;
	// about a dozen cycles per pixel at the longest ack delays
	localparam longint watchdog_ns  = 100 * (longint'(total_blocks) * pixels_per_block * 12
		+ longint'(moves + 2) * (`CALM_PERIOD + 50));

	// one entry per move, calm moves then aggressive ones then the knockout
	localparam logic [0:7][3:0] health_script = {4'd15, 4'd15, 4'd15, 4'd15,
	                                             4'd5, 4'd5, 4'd5, 4'd0};
	localparam logic [0:7]      dodge_script  = 8'b0101_1010;

	logic     clock;
	logic     reset_n;
	health_t  health;
	logic     dodge;
	pixel_t   pixel;
	logic     pixel_req;
	logic     pixel_ack;

	logic [31:0] lcg_state;
	logic        prev_req;
	logic        prev_ack;
	pixel_t      prev_pixel;
	sprite_t     cur_sprite;
	model_t      pause_model;
	int          blocks_done;
	int          pix_idx;
	int          idle;
	int          req_rises;
	int          checks;
	int          errors;
	int          proto_errors;
	int          tests_ok;
	int          start_err;
	int          rises_before;
	int          m;

	game_top u_game_top (
		.clock     (clock),
		.reset_n   (reset_n),
		.health    (health),
		.dodge     (dodge),
		.pixel     (pixel),
		.pixel_req (pixel_req),
		.pixel_ack (pixel_ack)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// 0 left, 1 middle, 2 right
	function automatic logic [1:0] next_column(input logic [1:0] col, input logic dg);
		case (col)
			2'd0:    return dg ? 2'd2 : 2'd1;
			2'd1:    return dg ? 2'd2 : 2'd0;
			default: return dg ? 2'd1 : 2'd0;
		endcase
	endfunction

	function automatic coord_x_t column_x(input logic [1:0] col);
		case (col)
			2'd0:    return coord_x_t'(`COL_LEFT_X);
			2'd1:    return coord_x_t'(`COL_MID_X);
			default: return coord_x_t'(`COL_RIGHT_X);
		endcase
	endfunction

	function automatic model_t model_after(input int done_moves);
		model_t md;
		int     k;
		md = '0;
		for (k = 0; k < done_moves; k++)
		begin
			if (!md.gone)
			begin
				if (health_script[k[2:0]] == 4'd0)
					md.gone = 1'b1;
				else
				begin
					md.col = next_column(md.col, dodge_script[k[2:0]]);
					if (health_script[k[2:0]] < 4'(`AGGRESSIVE_HEALTH))
						md.angry = 1'b1;
				end
			end
		end
		return md;
	endfunction

	// blocks 0 to 3 are the opening scene, block 4 + k follows move k
	function automatic sprite_t expected_sprite(input int n);
		sprite_t s;
		model_t  md;
		s.base_y = coord_y_t'(`HAND_Y);
		s.colour = colour_t'(`HAND_COLOUR);
		case (n)
			1: s.base_x = coord_x_t'(`LEFT_HAND_X);
			3: s.base_x = coord_x_t'(`RIGHT_HAND_X);
			2:
			begin
				s.base_x = coord_x_t'(`PLAYER_X);
				s.colour = colour_t'(`PLAYER_COLOUR);
			end
			default:
			begin
				md = model_after((n == 0) ? 0 : n - 3);
				s.base_x = column_x(md.col);
				s.base_y = coord_y_t'(`ENEMY_Y);
				s.colour = md.gone ? colour_t'(`ERASE_COLOUR) : colour_t'(`ENEMY_COLOUR);
			end
		endcase
		return s;
	endfunction

	task automatic check_pixel();
		coord_x_t exp_x;
		coord_y_t exp_y;
		if (blocks_done >= total_blocks)
		begin
			errors++;
			$display("at %0t ns a pixel was written after drawing should have stopped", $time);
		end
		else
		begin
			if (pix_idx == 0)
				cur_sprite = expected_sprite(blocks_done);
			exp_x = cur_sprite.base_x + coord_x_t'(pix_idx % `SPRITE_W);
			exp_y = cur_sprite.base_y + coord_y_t'(pix_idx / `SPRITE_W);
			checks++;
			if (pixel.x != exp_x)
			begin
				errors++;
				$display("error at %0t ns: pixel.x expected %0d got %0d", $time, exp_x, pixel.x);
			end
			if (pixel.y != exp_y)
			begin
				errors++;
				$display("error at %0t ns: pixel.y expected %0d got %0d", $time, exp_y, pixel.y);
			end
			if (pixel.colour != cur_sprite.colour)
			begin
				errors++;
				$display("error at %0t ns: pixel.colour expected %b got %b", $time,
					cur_sprite.colour, pixel.colour);
			end
			pix_idx++;
			if (pix_idx == pixels_per_block)
			begin
				pix_idx = 0;
				blocks_done++;
			end
		end
	endtask

	task automatic report_test(input int num, input string name, input int errs);
		if (errs == 0)
		begin
			tests_ok++;
			$display("test %0d (%s): ok", num, name);
		end
		else
			$display("test %0d (%s): FAIL with %0d errors", num, name, errs);
	endtask

	initial
	begin
		clock = 1'b0;
		forever
			#50 clock = ~clock;
	end

	// frame buffer side, random 0 to 3 cycle delay before each ack edge
	initial
	begin
		pixel_ack = 1'b0;
		lcg_state = 32'hfc82;
		forever
		begin
			@(negedge clock);
			if (pixel_req != pixel_ack)
			begin
				lcg_state = lcg_next(lcg_state);
				repeat (lcg_state[17:16])
					@(negedge clock);
				@(posedge clock);
				pixel_ack <= ~pixel_ack;
			end
		end
	end

	// compare process, samples on the falling edge
	initial
	begin
		prev_req   = 1'b0;
		prev_ack   = 1'b0;
		prev_pixel = '0;
		forever
		begin
			@(negedge clock);
			if (!reset_n)
			begin
				checks++;
				if (pixel_req)
				begin
					errors++;
					$display("error at %0t ns: pixel_req expected 0 got 1", $time);
				end
			end
			else
			begin
				if (pixel_req && !prev_req)
				begin
					req_rises++;
					checks++;
					if (pixel_ack)
					begin
						proto_errors++;
						$display("at %0t ns pixel_req rose while pixel_ack was still high", $time);
					end
					// pause before a redraw follows the enemy's mood
					if (blocks_done >= 4 && pix_idx == 0 && blocks_done < total_blocks)
					begin
						pause_model = model_after(blocks_done - 4);
						checks++;
						if (pause_model.angry && idle >= `CALM_PERIOD)
						begin
							errors++;
							$display("at %0t ns aggressive pause of %0d cycles was too long",
								$time, idle);
						end
						if (!pause_model.angry && idle <= `CALM_PERIOD)
						begin
							errors++;
							$display("at %0t ns calm pause of %0d cycles was too short",
								$time, idle);
						end
					end
				end
				if (pixel_req && prev_req && pixel != prev_pixel)
				begin
					proto_errors++;
					$display("at %0t ns pixel changed while pixel_req was high", $time);
				end
				if (pixel_ack && !prev_ack)
					check_pixel();
				if (pixel_req)
					idle = 0;
				else
					idle++;
			end
			prev_req   = pixel_req;
			prev_ack   = pixel_ack;
			prev_pixel = pixel;
		end
	end

	initial
	begin
		#(watchdog_ns);
		$display("timeout: only %0d of %0d blocks drawn", blocks_done, total_blocks);
		$display("tests failed");
		$finish;
	end

	initial
	begin
		reset_n      = 1'b0;
		health       = health_script[0];
		dodge        = dodge_script[0];
		blocks_done  = 0;
		pix_idx      = 0;
		idle         = 0;
		req_rises    = 0;
		checks       = 0;
		errors       = 0;
		proto_errors = 0;
		tests_ok     = 0;
		start_err    = 0;
		repeat (8)
			@(posedge clock);
		reset_n <= 1'b1;

		wait (blocks_done == 4);
		report_test(1, "opening scene", errors - start_err);
		start_err = errors;

		// next move's inputs go out once the previous redraw is finished
		for (m = 0; m < moves; m++)
		begin
			wait (blocks_done == 5 + m);
			@(posedge clock);
			if (m + 1 < moves)
			begin
				health <= health_script[m + 1];
				dodge  <= dodge_script[m + 1];
			end
			if (m == 3 || m == 6)
			begin
				if (m == 3)
					report_test(3, "calm moves", errors - start_err);
				else
					report_test(4, "aggressive moves", errors - start_err);
				start_err = errors;
			end
		end

		// dead enemy, nothing more may be drawn
		rises_before = req_rises;
		repeat (2 * `CALM_PERIOD)
			@(posedge clock);
		checks++;
		if (req_rises != rises_before)
		begin
			errors++;
			$display("pixel_req rose again after the enemy was drawn dead");
		end
		report_test(5, "knockout", errors - start_err);
		report_test(2, "handshake under random ack delays", proto_errors);

		$display("summary: %0d of 5 tests ok, %0d checks, %0d errors", tests_ok, checks,
			errors + proto_errors);
		if (errors + proto_errors == 0 && tests_ok == 5)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
game_pkg.sv
sprite_blitter.sv
move_timer.sv
enemy_behaviour.sv
scene_sequencer.sv
game_top.sv
tb_game_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the boxing game drawing engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_game_top -f build.f -o sim_game
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/sim_game > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "all tests passed" sim.log; then
	exit 0
fi
exit 1
